/* compile.f */
design/hc_pkg.sv
design/host_chan_events.sv
design/host_chan_mmio.sv
design/host_chan_port.sv
design/host_chan_top.sv
tests/tb_clk_gen.sv
tests/host_chan_chk.sv
tests/host_chan_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the host-channel monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module host_chan_tb -f compile.f -o host_chan_sim

# The simulator exit code is not trusted, the log decides
./obj_dir/host_chan_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Result: testbench reported failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Result: run ended without completing"
    exit 1
fi
echo "Result: ok"

/* tests/host_chan_tb.sv */
// Testbench for the host-channel monitor
// Random request and completion traffic, MMIO reads and writes,
// power-state changes, a per-port reference model and a watchdog

`timescale 1ns/1ps

module host_chan_tb
    import hc_pkg::*;
();

    localparam int CLK_PERIOD_NS  = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int TRAFFIC_CYCLES = 2000;
    localparam int PWR_CHANGES    = 8;
    localparam int TEST_CYCLES    = RESET_CYCLES + 18 + TRAFFIC_CYCLES
                                    + 7 * NUM_PORTS + 3 * PWR_CHANGES + 2;
    localparam int TIMEOUT_NS     = (TEST_CYCLES + 50) * CLK_PERIOD_NS;

    localparam logic [ADDR_W-1:0] COUNTER_REGS [4] =
        '{REG_REQ_CNT, REG_CPL_CNT, REG_OUTSTANDING, REG_LATENCY_SUM};

    logic                        clk;
    logic                        rst_n;
    t_power_state                pwr_state;
    logic [NUM_PORTS-1:0]        req_strobe;
    logic [NUM_PORTS-1:0]        cpl_strobe;
    logic [NUM_PORTS-1:0]        mmio_rd;
    logic [NUM_PORTS-1:0]        mmio_wr;
    logic [NUM_PORTS*ADDR_W-1:0] mmio_addr;
    logic [NUM_PORTS*CNT_W-1:0]  mmio_wdata;
    logic [NUM_PORTS-1:0]        mmio_rd_valid;
    logic [NUM_PORTS*CNT_W-1:0]  mmio_rdata;

    // Reference model state per port
    logic [CNT_W-1:0]  m_req [NUM_PORTS];
    logic [CNT_W-1:0]  m_cpl [NUM_PORTS];
    logic [CNT_W-1:0]  m_outst [NUM_PORTS];
    logic [CNT_W-1:0]  m_lat [NUM_PORTS];
    logic [CNT_W-1:0]  m_scratch [NUM_PORTS];
    t_power_state      pwr_seen;

    // Reads waiting for their response
    logic              pend [NUM_PORTS];
    logic [ADDR_W-1:0] pend_addr [NUM_PORTS];
    logic [CNT_W-1:0]  pend_exp [NUM_PORTS];

    tb_clk_gen clk_gen_i (.clk(clk));

    host_chan_top host_chan_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pwr_state     (pwr_state),
        .req_strobe    (req_strobe),
        .cpl_strobe    (cpl_strobe),
        .mmio_rd       (mmio_rd),
        .mmio_wr       (mmio_wr),
        .mmio_addr     (mmio_addr),
        .mmio_wdata    (mmio_wdata),
        .mmio_rd_valid (mmio_rd_valid),
        .mmio_rdata    (mmio_rdata)
    );

    bind host_chan_events host_chan_chk chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpl_strobe  (cpl_strobe),
        .clear       (clear),
        .req_cnt     (req_cnt),
        .cpl_cnt     (cpl_cnt),
        .outstanding (outstanding),
        .latency_sum (latency_sum)
    );

    // ======================================================================
    // Reference model updated at every rising edge
    // ======================================================================

    always @(posedge clk)
    begin : reference_model
        logic              req;
        logic              cpl;
        logic              clr;
        logic [ADDR_W-1:0] a;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            req = req_strobe[p];
            cpl = cpl_strobe[p];
            a   = mmio_addr[p*ADDR_W +: ADDR_W];
            clr = mmio_wr[p] && (a == REG_CTRL) && mmio_wdata[p*CNT_W];
            if (!rst_n || clr)
            begin
                m_req[p]   = '0;
                m_cpl[p]   = '0;
                m_outst[p] = '0;
                m_lat[p]   = '0;
            end
            else
            begin
                // Integrate the count held before this edge
                m_lat[p] = m_lat[p] + m_outst[p];
                if (req)
                    m_req[p] = m_req[p] + CNT_W'(1);
                if (cpl)
                    m_cpl[p] = m_cpl[p] + CNT_W'(1);
                if (req && !cpl)
                    m_outst[p] = m_outst[p] + CNT_W'(1);
                else if (cpl && !req)
                    m_outst[p] = m_outst[p] - CNT_W'(1);
            end
            if (!rst_n)
                m_scratch[p] = '0;
            else if (mmio_wr[p] && (a == REG_SCRATCH))
                m_scratch[p] = mmio_wdata[p*CNT_W +: CNT_W];
        end
    end

    function automatic logic [CNT_W-1:0] expected_read(input int p,
                                                       input logic [ADDR_W-1:0] a);
        case (a)
            REG_REQ_CNT:     return m_req[p];
            REG_CPL_CNT:     return m_cpl[p];
            REG_OUTSTANDING: return m_outst[p];
            REG_LATENCY_SUM: return m_lat[p];
            REG_PWR_STATE:   return CNT_W'(pwr_seen);
            REG_SCRATCH:     return m_scratch[p];
            // Control register reads back as zero
            REG_CTRL:        return '0;
            default:         return BAD_ADDR_DATA;
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] pick_counter_reg();
        return COUNTER_REGS[$urandom % 4];
    endfunction

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_responses();
        logic [CNT_W-1:0] got;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            got = mmio_rdata[p*CNT_W +: CNT_W];
            if (pend[p])
            begin
                assert (mmio_rd_valid[p])
                else fail_now($sformatf(
                    "Port %0d gave no read response in the cycle after the read", p));
                assert (got == pend_exp[p])
                else fail_now($sformatf(
                    "[FAIL] t=%0t port %0d mmio_rdata (addr %0d) expected %h actual %h",
                    $time, p, pend_addr[p], pend_exp[p], got));
            end
            else
            begin
                assert (!mmio_rd_valid[p])
                else fail_now($sformatf("Port %0d gave a read response without a read", p));
            end
            pend[p] = 1'b0;
        end
    endtask

    // Wait for the falling edge, check last cycle's reads, drop all strobes
    task automatic next_cycle();
        @(negedge clk);
        check_responses();
        req_strobe = '0;
        cpl_strobe = '0;
        mmio_rd    = '0;
        mmio_wr    = '0;
    endtask

    task automatic drive_strobes(input logic [NUM_PORTS-1:0] active);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (active[p])
            begin
                req_strobe[p] = ($urandom % 100) < 45;
                // No completion unless something is in flight
                cpl_strobe[p] = (m_outst[p] != '0) && (($urandom % 100) < 45);
            end
        end
    endtask

    task automatic issue_read(input int p, input logic [ADDR_W-1:0] a);
        mmio_rd[p]                    = 1'b1;
        mmio_addr[p*ADDR_W +: ADDR_W] = a;
        pend[p]                       = 1'b1;
        pend_addr[p]                  = a;
        pend_exp[p]                   = expected_read(p, a);
    endtask

    task automatic issue_write(input int p, input logic [ADDR_W-1:0] a,
                               input logic [CNT_W-1:0] d);
        mmio_wr[p]                    = 1'b1;
        mmio_addr[p*ADDR_W +: ADDR_W] = a;
        mmio_wdata[p*CNT_W +: CNT_W]  = d;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin : stimulus
        logic [NUM_PORTS-1:0] others;
        t_power_state         new_state;
        void'($urandom(89012));
        rst_n      = 1'b0;
        pwr_state  = PWR_NORMAL;
        pwr_seen   = PWR_NORMAL;
        req_strobe = '0;
        cpl_strobe = '0;
        mmio_rd    = '0;
        mmio_wr    = '0;
        mmio_addr  = '0;
        mmio_wdata = '0;
        for (int p = 0; p < NUM_PORTS; p++)
            pend[p] = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Whole address space after reset
        for (int a = 0; a < 16; a++)
        begin
            next_cycle();
            for (int p = 0; p < NUM_PORTS; p++)
                issue_read(p, ADDR_W'(a));
        end

        // Random traffic with counter reads
        for (int c = 0; c < TRAFFIC_CYCLES; c++)
        begin
            next_cycle();
            drive_strobes('1);
            for (int p = 0; p < NUM_PORTS; p++)
                if (($urandom % 3) == 0)
                    issue_read(p, pick_counter_reg());
        end

        // Scratch per port
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            next_cycle();
            drive_strobes('1);
            issue_write(p, REG_SCRATCH, {$urandom, $urandom});
            next_cycle();
            drive_strobes('1);
            for (int q = 0; q < NUM_PORTS; q++)
                issue_read(q, REG_SCRATCH);
        end

        // Clear one port while the others keep running
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            others    = '1;
            others[p] = 1'b0;
            next_cycle();
            drive_strobes('1);
            issue_write(p, REG_CTRL, CNT_W'(1));
            for (int k = 0; k < 4; k++)
            begin
                next_cycle();
                drive_strobes(others);
                for (int q = 0; q < NUM_PORTS; q++)
                    issue_read(q, COUNTER_REGS[k]);
            end
        end

        // Power state is read at the third edge after a change
        for (int k = 0; k < PWR_CHANGES; k++)
        begin
            next_cycle();
            drive_strobes('1);
            new_state = t_power_state'(2'($urandom % 4));
            pwr_state = new_state;
            next_cycle();
            drive_strobes('1);
            next_cycle();
            drive_strobes('1);
            pwr_seen = new_state;
            for (int p = 0; p < NUM_PORTS; p++)
                issue_read(p, REG_PWR_STATE);
        end

        next_cycle();
        next_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        fail_now("Timeout: the test sequence did not finish in the expected time");
    end

endmodule : host_chan_tb

/* tests/host_chan_chk.sv */
// Concurrent checks on the host-channel event tracker
// Completion ordering, in-flight count consistency, clear behavior

`timescale 1ns/1ps

module host_chan_chk
    import hc_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cpl_strobe,
    input  logic             clear,
    input  logic [CNT_W-1:0] req_cnt,
    input  logic [CNT_W-1:0] cpl_cnt,
    input  logic [CNT_W-1:0] outstanding,
    input  logic [CNT_W-1:0] latency_sum
);

    // The host only answers requests that are in flight
    cpl_needs_inflight: assert property (@(posedge clk) disable iff (!rst_n)
        cpl_strobe |-> (outstanding != '0))
        else $error("completion strobe while no request is outstanding");

    outstanding_matches_totals: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding == (req_cnt - cpl_cnt))
        else $error("outstanding count differs from requests minus completions");

    // Strobes in the clearing cycle are dropped, so everything is zero
    clear_zeroes_counters: assert property (@(posedge clk) disable iff (!rst_n)
        clear |=> (req_cnt == '0) && (cpl_cnt == '0) && (outstanding == '0)
                  && (latency_sum == '0))
        else $error("counters not zero in the cycle after a clear");

endmodule : host_chan_chk

/* tests/tb_clk_gen.sv */
// Testbench clock generator
// Free-running clock with a 20 ns period

`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk
);

    localparam int HALF_PERIOD_NS = 10;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule : tb_clk_gen

/* design/host_chan_top.sv */
// Host-channel monitor top level
// NUM_PORTS independent ports on flattened port vectors

`timescale 1ns/1ps

module host_chan_top
    import hc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // Shared by all ports, asynchronous to clk
    input  t_power_state                pwr_state,

    input  logic [NUM_PORTS-1:0]        req_strobe,
    input  logic [NUM_PORTS-1:0]        cpl_strobe,

    input  logic [NUM_PORTS-1:0]        mmio_rd,
    input  logic [NUM_PORTS-1:0]        mmio_wr,
    input  logic [NUM_PORTS*ADDR_W-1:0] mmio_addr,
    input  logic [NUM_PORTS*CNT_W-1:0]  mmio_wdata,

    output logic [NUM_PORTS-1:0]        mmio_rd_valid,
    output logic [NUM_PORTS*CNT_W-1:0]  mmio_rdata
);

    // ======================================================================
    // One monitor per host port
    // ======================================================================

    genvar p;
    generate
        for (p = 0; p < NUM_PORTS; p = p + 1)
        begin : hc
            host_chan_port port_i (
                .clk           (clk),
                .rst_n         (rst_n),
                .req_strobe    (req_strobe[p]),
                .cpl_strobe    (cpl_strobe[p]),
                .pwr_state     (pwr_state),
                .mmio_rd       (mmio_rd[p]),
                .mmio_wr       (mmio_wr[p]),
                .mmio_addr     (mmio_addr[p*ADDR_W +: ADDR_W]),
                .mmio_wdata    (mmio_wdata[p*CNT_W +: CNT_W]),
                .mmio_rd_valid (mmio_rd_valid[p]),
                .mmio_rdata    (mmio_rdata[p*CNT_W +: CNT_W])
            );
        end
    endgenerate

endmodule : host_chan_top

/* design/host_chan_port.sv */
// One host-channel monitor port
// Power-state synchronizer into clk, event tracker, MMIO block

`timescale 1ns/1ps

module host_chan_port
    import hc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_strobe,
    input  logic              cpl_strobe,
    input  t_power_state      pwr_state,

    input  logic              mmio_rd,
    input  logic              mmio_wr,
    input  logic [ADDR_W-1:0] mmio_addr,
    input  logic [CNT_W-1:0]  mmio_wdata,

    output logic              mmio_rd_valid,
    output logic [CNT_W-1:0]  mmio_rdata
);

    t_power_state     pwr_meta;
    t_power_state     pwr_sync;

    logic             clear;
    logic [CNT_W-1:0] req_cnt;
    logic [CNT_W-1:0] cpl_cnt;
    logic [CNT_W-1:0] outstanding;
    logic [CNT_W-1:0] latency_sum;

    // ======================================================================
    // Power state into clk, two flops
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_meta <= PWR_NORMAL;
            pwr_sync <= PWR_NORMAL;
        end
        else
        begin
            pwr_meta <= pwr_state;
            pwr_sync <= pwr_meta;
        end
    end

    // ======================================================================
    // Event tracker and register block
    // ======================================================================

    host_chan_events events_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_strobe  (req_strobe),
        .cpl_strobe  (cpl_strobe),
        .clear       (clear),
        .req_cnt     (req_cnt),
        .cpl_cnt     (cpl_cnt),
        .outstanding (outstanding),
        .latency_sum (latency_sum)
    );

    host_chan_mmio mmio_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_rd       (mmio_rd),
        .mmio_wr       (mmio_wr),
        .mmio_addr     (mmio_addr),
        .mmio_wdata    (mmio_wdata),
        .req_cnt       (req_cnt),
        .cpl_cnt       (cpl_cnt),
        .outstanding   (outstanding),
        .latency_sum   (latency_sum),
        .pwr_state     (pwr_sync),
        .mmio_rd_valid (mmio_rd_valid),
        .mmio_rdata    (mmio_rdata),
        .clear         (clear)
    );

endmodule : host_chan_port

/* design/host_chan_mmio.sv */
// MMIO register block for one host-channel port
// Address decode, registered 64-bit read path, scratch register
// and the counter clear pulse

`timescale 1ns/1ps

module host_chan_mmio
    import hc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              mmio_rd,
    input  logic              mmio_wr,
    input  logic [ADDR_W-1:0] mmio_addr,
    input  logic [CNT_W-1:0]  mmio_wdata,

    input  logic [CNT_W-1:0]  req_cnt,
    input  logic [CNT_W-1:0]  cpl_cnt,
    input  logic [CNT_W-1:0]  outstanding,
    input  logic [CNT_W-1:0]  latency_sum,
    input  t_power_state      pwr_state,

    output logic              mmio_rd_valid,
    output logic [CNT_W-1:0]  mmio_rdata,
    output logic              clear
);

    logic [CNT_W-1:0] scratch;
    logic [CNT_W-1:0] rd_value;

    // ======================================================================
    // Write side
    // ======================================================================

    // Clear goes out in the same cycle as the write
    assign clear = mmio_wr && (mmio_addr == REG_CTRL) && mmio_wdata[0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scratch <= '0;
        end
        else if (mmio_wr && (mmio_addr == REG_SCRATCH))
        begin
            scratch <= mmio_wdata;
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================

    always_comb
    begin
        case (mmio_addr)
            REG_REQ_CNT:     rd_value = req_cnt;
            REG_CPL_CNT:     rd_value = cpl_cnt;
            REG_OUTSTANDING: rd_value = outstanding;
            REG_LATENCY_SUM: rd_value = latency_sum;
            REG_PWR_STATE:   rd_value = CNT_W'(pwr_state);
            REG_SCRATCH:     rd_value = scratch;
            // Control is write-only, the clear bit self-clears
            REG_CTRL:        rd_value = '0;
            default:         rd_value = BAD_ADDR_DATA;
        endcase
    end

    // Valid pulse for one cycle after the read strobe
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mmio_rd_valid <= 1'b0;
        end
        else
        begin
            mmio_rd_valid <= mmio_rd;
        end
    end

    // Capture the pre-edge register value
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            mmio_rdata <= rd_value;
        end
    end

endmodule : host_chan_mmio

/* design/host_chan_events.sv */
// Host-channel event tracker for one port
// Request, completion and in-flight counters plus a latency
// accumulator that integrates the in-flight count every cycle

`timescale 1ns/1ps

module host_chan_events
    import hc_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic             req_strobe,
    input  logic             cpl_strobe,
    input  logic             clear,

    output logic [CNT_W-1:0] req_cnt,
    output logic [CNT_W-1:0] cpl_cnt,
    output logic [CNT_W-1:0] outstanding,
    output logic [CNT_W-1:0] latency_sum
);

    logic [CNT_W-1:0] outstanding_nxt;

    // In-flight count moves only when exactly one strobe fires
    always_comb
    begin
        outstanding_nxt = outstanding;
        case ({req_strobe, cpl_strobe})
            2'b10:   outstanding_nxt = outstanding + CNT_W'(1);
            2'b01:   outstanding_nxt = outstanding - CNT_W'(1);
            default: outstanding_nxt = outstanding;
        endcase
    end

    // ======================================================================
    // Counters
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_cnt     <= '0;
            cpl_cnt     <= '0;
            outstanding <= '0;
            latency_sum <= '0;
        end
        else if (clear)
        begin
            // Strobes in the clearing cycle are dropped
            req_cnt     <= '0;
            cpl_cnt     <= '0;
            outstanding <= '0;
            latency_sum <= '0;
        end
        else
        begin
            if (req_strobe)
            begin
                req_cnt <= req_cnt + CNT_W'(1);
            end
            if (cpl_strobe)
            begin
                cpl_cnt <= cpl_cnt + CNT_W'(1);
            end
            outstanding <= outstanding_nxt;

            // Request-cycles in flight, using the pre-edge count
            latency_sum <= latency_sum + outstanding;
        end
    end

endmodule : host_chan_events

/* design/hc_pkg.sv */
// Shared definitions for the host-channel monitor
// Port count, counter and address widths, MMIO register map,
// platform power-state encoding

package hc_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================

    localparam int NUM_PORTS = 2;

    // Counters and the MMIO read path share one width
    localparam int CNT_W = 64;

    // MMIO word address
    localparam int ADDR_W = 4;

    // ======================================================================
    // Platform power state
    // ======================================================================

    typedef enum logic [1:0] {
        PWR_NORMAL = 2'd0,
        PWR_AP1    = 2'd1,
        PWR_AP2    = 2'd2,
        PWR_AP6    = 2'd3
    } t_power_state;

    // ======================================================================
    // MMIO register map (word addresses)
    // ======================================================================

    localparam logic [ADDR_W-1:0] REG_REQ_CNT     = 4'd0;
    localparam logic [ADDR_W-1:0] REG_CPL_CNT     = 4'd1;
    localparam logic [ADDR_W-1:0] REG_OUTSTANDING = 4'd2;
    localparam logic [ADDR_W-1:0] REG_LATENCY_SUM = 4'd3;
    localparam logic [ADDR_W-1:0] REG_PWR_STATE   = 4'd4;
    localparam logic [ADDR_W-1:0] REG_SCRATCH     = 4'd5;
    // Bit 0 of a write clears the event counters
    localparam logic [ADDR_W-1:0] REG_CTRL        = 4'd6;

    // Returned for any address outside the map
    localparam logic [CNT_W-1:0] BAD_ADDR_DATA = 64'hBAD0_ADD0_DEAD_BEEF;

endpackage : hc_pkg
